// ==== test/com_link_patterns.txt ====
// one word per line: cmd_arg_value, cmd 01 raw byte, 02 payload byte, 03 crc5 ^ arg,
// 04 crc16 ^ arg, 05 expect btype arg len value, 06 ram[arg] == value, 07 fd, 08 gap, FF end.
08_00_0000
01_01_0000
01_2D_0000
05_01_0000
07_00_0000
08_00_0000
01_01_0000
01_A5_0000
05_02_0000
07_00_0000
// junk before sync, then bytes while fs is high.
01_55_0000
01_AA_0000
01_1E_0000
01_01_0000
01_E1_0000
05_03_0000
01_01_0000
01_2D_0000
05_03_0000
07_00_0000
// cmd into device-index region.
08_00_0000
01_01_0000
01_1E_0000
01_00_0000
01_03_0000
02_9A_0000
02_BC_0000
02_DE_0000
03_00_0000
05_08_0003
07_00_0000
06_10_009A
06_12_00DE
// data0 into data-index region.
01_01_0000
01_C3_0000
01_00_0000
01_04_0000
02_12_0000
02_34_0000
02_56_0000
02_78_0000
04_00_0000
05_0D_0004
07_00_0000
06_20_0012
06_23_0078
// data1 into parameter region.
08_00_0000
01_01_0000
01_4B_0000
01_00_0000
01_02_0000
02_5F_0000
02_A0_0000
04_00_0000
05_0E_0002
07_00_0000
06_80_005F
06_81_00A0
// data0 into device-index region.
01_01_0000
01_C3_0000
01_00_0000
01_01_0000
02_93_0000
04_00_0000
05_0D_0001
07_00_0000
06_10_0093
// bad crc5, payload still written.
01_01_0000
01_1E_0000
01_00_0000
01_02_0000
02_57_0000
02_66_0000
03_01_0000
05_0F_0002
07_00_0000
06_80_0057
06_81_0066
// bad crc16 low byte.
01_01_0000
01_4B_0000
01_00_0000
01_01_0000
02_1C_0000
04_FF_0000
05_0F_0001
07_00_0000
06_20_001C
// unknown pid, zero length, too long.
01_01_0000
01_77_0000
05_0F_0000
07_00_0000
01_01_0000
01_1E_0000
01_00_0000
01_00_0000
05_0F_0000
07_00_0000
01_01_0000
01_C3_0000
01_00_0000
01_41_0000
05_0F_0041
07_00_0000
// unknown header, regions untouched.
01_01_0000
01_1E_0000
01_00_0000
01_02_0000
01_3A_0000
01_44_0000
05_0F_0002
07_00_0000
06_10_0093
06_20_001C
06_80_0057
// recovery packet.
08_00_0000
01_01_0000
01_1E_0000
01_00_0000
01_01_0000
02_9F_0000
03_00_0000
05_08_0001
07_00_0000
06_10_009F
FF_00_0000

// ==== files.f ====
+incdir+hdl
hdl/com_pkg.sv
hdl/crc5.sv
hdl/crc16.sv
hdl/com_rx.sv
hdl/param_ram.sv
hdl/com_link.sv
test/tb_com_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_com_link \
    -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build step returned an error"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== test/tb_com_link.sv ====
`include "com_cfg.svh"

module tb_com_link
    import com_pkg::*;
();

    logic   clk;
    logic   rst;
    byte_t  com_rxd;
    logic   fd;
    addr_t  rd_addr;
    logic   fs;
    pkt_type_e btype;
    len_t   rx_len;
    byte_t  rd_data;

    logic [31:0] pat [0:255];
    byte_t       payload [$];

    com_link uut (
        .clk     (clk),
        .rst     (rst),
        .com_rxd (com_rxd),
        .fd      (fd),
        .rd_addr (rd_addr),
        .fs      (fs),
        .btype   (btype),
        .rx_len  (rx_len),
        .rd_data (rd_data)
    );

    always #20 clk = ~clk;

    // ========================================================================
    // error handling and checks.
    // ========================================================================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                    name, got, exp));
        end
    endtask

    // ========================================================================
    // usb style reference crcs with the lsb first.
    // ========================================================================
    function automatic logic [4:0] crc5_of_payload();
        logic [4:0] r;
        logic [4:0] poly;
        logic [4:0] rpoly;
        logic [4:0] c;
        byte_t      d;
        poly = `COM_CRC5_POLY;
        // reflected register needs the mirrored polynomial.
        for (int j = 0; j < 5; j++) begin
            rpoly[j] = poly[4 - j];
        end
        r = `COM_CRC5_INIT;
        foreach (payload[k]) begin
            d = payload[k];
            for (int i = 0; i < 8; i++) begin
                r = (r[0] ^ d[i]) ? ((r >> 1) ^ rpoly) : (r >> 1);
            end
        end
        for (int j = 0; j < 5; j++) begin
            c[j] = r[4 - j];
        end
        return ~c;
    endfunction

    function automatic logic [15:0] crc16_of_payload();
        logic [15:0] r;
        r = `COM_CRC16_INIT;
        foreach (payload[k]) begin
            r = r ^ {8'h00, payload[k]};
            for (int i = 0; i < 8; i++) begin
                r = r[0] ? ((r >> 1) ^ `COM_CRC16_POLY) : (r >> 1);
            end
        end
        return ~r;
    endfunction

    // ========================================================================
    // stimulus tasks drive on the falling edge.
    // ========================================================================
    task automatic drive_byte(input byte_t b);
        @(negedge clk);
        com_rxd = b;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        com_rxd = 8'h00;
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom_range(0, 6);
        repeat (n) idle_cycle();
    endtask

    task automatic send_crc5(input byte_t flip);
        logic [4:0] c;
        c = crc5_of_payload();
        drive_byte({3'b000, c} ^ flip);
        payload.delete();
    endtask

    task automatic send_crc16(input byte_t flip);
        logic [15:0] c;
        c = crc16_of_payload();
        drive_byte(c[7:0] ^ flip);
        drive_byte(c[15:8]);
        payload.delete();
    endtask

    task automatic expect_status(input logic [3:0] typ, input len_t len);
        int n;
        n = 0;
        while (!fs && n < 200) begin
            idle_cycle();
            n++;
        end
        if (!fs) begin
            stop_on_error("timeout while waiting for fs to go high");
        end
        check("btype", 32'(btype), 32'(typ));
        check("rx_len", 32'(rx_len), 32'(len));
    endtask

    task automatic ack_status();
        int delay;
        int n;
        delay = $urandom_range(0, 7);
        repeat (delay) idle_cycle();
        check("fs", 32'(fs), 32'd1);
        @(negedge clk);
        com_rxd = 8'h00;
        fd = 1'b1;
        @(negedge clk);
        fd = 1'b0;
        n = 0;
        while (fs && n < 20) begin
            idle_cycle();
            n++;
        end
        if (fs) begin
            stop_on_error("timeout while waiting for fs to fall after fd");
        end
    endtask

    task automatic read_ram(input addr_t addr, input byte_t exp);
        @(negedge clk);
        com_rxd = 8'h00;
        rd_addr = addr;
        @(negedge clk);
        check("rd_data", 32'(rd_data), 32'(exp));
    endtask

    // ========================================================================
    // main sequence.
    // ========================================================================
    initial begin
        logic [31:0] w;
        logic        running;
        int          i;
        clk     = 1'b0;
        rst     = 1'b1;
        com_rxd = 8'h00;
        fd      = 1'b0;
        rd_addr = 8'h00;
        void'($urandom(32'ha083ba83));
        $readmemh("test/com_link_patterns.txt", pat);

        repeat (5) @(negedge clk);
        rst = 1'b0;
        idle_cycle();
        check("fs", 32'(fs), 32'd0);
        check("btype", 32'(btype), 32'(NONE));
        check("rx_len", 32'(rx_len), 32'd0);

        running = 1'b1;
        i = 0;
        while (running && i < 256) begin
            w = pat[i];
            case (w[31:24])
                8'h01: drive_byte(w[23:16]);
                8'h02: begin
                    payload.push_back(w[23:16]);
                    drive_byte(w[23:16]);
                end
                8'h03: send_crc5(w[23:16]);
                8'h04: send_crc16(w[23:16]);
                8'h05: expect_status(w[19:16], w[15:0]);
                8'h06: read_ram(w[23:16], w[7:0]);
                8'h07: ack_status();
                8'h08: idle_gap();
                8'hFF: running = 1'b0;
                default: stop_on_error($sformatf("unknown command 0x%0h at entry %0d",
                                                 w[31:24], i));
            endcase
            i++;
        end

        if (running) begin
            stop_on_error("pattern file has no end marker");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== hdl/com_link.sv ====
module com_link
    import com_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  byte_t     com_rxd,
    input  logic      fd,
    input  addr_t     rd_addr,
    output logic      fs,
    output pkt_type_e btype,
    output len_t      rx_len,
    output byte_t     rd_data
);

    logic   crc_clr;
    logic   crc_en;
    crc5_t  crc5_val;
    crc16_t crc16_val;
    addr_t  ram_txa;
    byte_t  ram_txd;
    logic   ram_txen;

    // ========================================================================
    // packet parser.
    // ========================================================================
    com_rx u_com_rx (
        .clk       (clk),
        .rst       (rst),
        .com_rxd   (com_rxd),
        .fd        (fd),
        .crc5_val  (crc5_val),
        .crc16_val (crc16_val),
        .fs        (fs),
        .btype     (btype),
        .rx_len    (rx_len),
        .crc_clr   (crc_clr),
        .crc_en    (crc_en),
        .ram_txa   (ram_txa),
        .ram_txd   (ram_txd),
        .ram_txen  (ram_txen)
    );

    // both crcs run on every payload, the parser picks one by pid.
    crc5 u_crc5 (
        .clk (clk),
        .rst (rst),
        .clr (crc_clr),
        .en  (crc_en),
        .din (com_rxd),
        .crc (crc5_val)
    );

    crc16 u_crc16 (
        .clk (clk),
        .rst (rst),
        .clr (crc_clr),
        .en  (crc_en),
        .din (com_rxd),
        .crc (crc16_val)
    );

    param_ram u_param_ram (
        .clk   (clk),
        .we    (ram_txen),
        .waddr (ram_txa),
        .wdata (ram_txd),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

// ==== hdl/param_ram.sv ====
module param_ram
    import com_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  addr_t waddr,
    input  byte_t wdata,
    input  addr_t raddr,
    output byte_t rdata
);

    byte_t mem [256];

    // cleared at start of simulation.
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data lands one edge after the address, old data on a collision.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hdl/com_rx.sv ====
`include "com_cfg.svh"

module com_rx
    import com_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  byte_t     com_rxd,
    input  logic      fd,
    input  crc5_t     crc5_val,
    input  crc16_t    crc16_val,
    output logic      fs,
    output pkt_type_e btype,
    output len_t      rx_len,
    output logic      crc_clr,
    output logic      crc_en,
    output addr_t     ram_txa,
    output byte_t     ram_txd,
    output logic      ram_txen
);

    rx_state_e state;
    rx_state_e state_nx;
    byte_t     rxd_q;
    len_t      cnt;
    len_t      len_in;
    pkt_type_e pid_type;
    logic      head_ok;
    addr_t     head_base;
    logic      len_last;
    logic      pay_last;

    // ========================================================================
    // input byte and decoders.
    // ========================================================================
    always_ff @(posedge clk) begin
        rxd_q <= com_rxd;
    end

    // full length once the low byte is in rxd_q.
    assign len_in   = {rx_len[15:8], rxd_q};
    assign len_last = (state == DLEN) && (cnt == 16'd1);
    assign pay_last = (cnt == rx_len - 16'd1);

    always_comb begin
        case (rxd_q)
            `COM_PID_ACK:   pid_type = ACK;
            `COM_PID_NAK:   pid_type = NAK;
            `COM_PID_STL:   pid_type = STALL;
            `COM_PID_CMD:   pid_type = CMD;
            `COM_PID_DATA0: pid_type = DATA0;
            `COM_PID_DATA1: pid_type = DATA1;
            default:        pid_type = ERROR;
        endcase
    end

    always_comb begin
        head_ok   = 1'b1;
        head_base = `COM_BASE_DIDX;
        case (rxd_q[7:4])
            `COM_HEAD_DIDX:   head_base = `COM_BASE_DIDX;
            `COM_HEAD_DDIDX:  head_base = `COM_BASE_DDIDX;
            `COM_HEAD_DPARAM: head_base = `COM_BASE_DPARAM;
            default:          head_ok = 1'b0;
        endcase
    end

    // ========================================================================
    // state machine.
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: state_nx = WAIT;
            WAIT: begin
                if (rxd_q == `COM_PID_SYNC) begin
                    state_nx = RPID;
                end
            end
            RPID: begin
                case (pid_type)
                    ACK, NAK, STALL:   state_nx = DONE;
                    CMD, DATA0, DATA1: state_nx = DLEN;
                    default:           state_nx = EROR;
                endcase
            end
            DLEN: begin
                if (cnt == 16'd1) begin
                    if (len_in == '0 || len_in > `COM_MAX_LEN) begin
                        state_nx = EROR;
                    end else begin
                        state_nx = WORK;
                    end
                end
            end
            WORK: begin
                // nothing is written for an unknown header.
                if (cnt == '0 && !head_ok) begin
                    state_nx = EROR;
                end else if (pay_last) begin
                    state_nx = (btype == CMD) ? CRC5 : CRC16;
                end
            end
            CRC5: state_nx = (rxd_q == {3'b000, crc5_val}) ? DONE : EROR;
            CRC16: begin
                if (cnt == '0) begin
                    if (rxd_q != crc16_val[7:0]) begin
                        state_nx = EROR;
                    end
                end else begin
                    state_nx = (rxd_q == crc16_val[15:8]) ? DONE : EROR;
                end
            end
            DONE: begin
                if (fd) begin
                    state_nx = WAIT;
                end
            end
            EROR:    state_nx = DONE;
            default: state_nx = IDLE;
        endcase
    end

    // shared byte counter for length, payload and crc bytes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (state_nx == state &&
                     (state == DLEN || state == WORK || state == CRC16)) begin
            cnt <= cnt + 16'd1;
        end else begin
            cnt <= '0;
        end
    end

    // ========================================================================
    // packet status.
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btype  <= NONE;
            rx_len <= '0;
        end else begin
            case (state)
                WAIT: begin
                    btype  <= NONE;
                    rx_len <= '0;
                end
                RPID: btype <= pid_type;
                DLEN: begin
                    if (cnt == '0) begin
                        rx_len[15:8] <= rxd_q;
                    end else begin
                        rx_len[7:0] <= rxd_q;
                    end
                end
                EROR: btype <= ERROR;
                default: ;
            endcase
        end
    end

    assign fs      = (state == DONE);
    assign crc_clr = (state == WAIT);
    // the crcs see com_rxd, one byte ahead of rxd_q.
    assign crc_en  = len_last || (state == WORK && !pay_last);

    // ========================================================================
    // ram write port.
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_txen <= 1'b0;
        end else begin
            ram_txen <= (state == WORK) && (cnt != '0 || head_ok);
        end
    end

    always_ff @(posedge clk) begin
        ram_txd <= rxd_q;
        if (state == WORK) begin
            if (cnt == '0) begin
                ram_txa <= head_base;
            end else begin
                ram_txa <= ram_txa + 8'd1;
            end
        end
    end

endmodule

// ==== hdl/crc16.sv ====
`include "com_cfg.svh"

module crc16
    import com_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   clr,
    input  logic   en,
    input  byte_t  din,
    output crc16_t crc
);

    crc16_t crc_q;

    // reflected register, so the remainder shifts right.
    function automatic crc16_t fold(crc16_t c, byte_t d);
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ `COM_CRC16_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= `COM_CRC16_INIT;
        end else if (clr) begin
            crc_q <= `COM_CRC16_INIT;
        end else if (en) begin
            crc_q <= fold(crc_q, din);
        end
    end

    // sent low byte first.
    assign crc = ~crc_q;

endmodule

// ==== hdl/crc5.sv ====
`include "com_cfg.svh"

module crc5
    import com_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  clr,
    input  logic  en,
    input  byte_t din,
    output crc5_t crc
);

    crc5_t crc_q;

    // one byte folded in, bit 0 first.
    function automatic crc5_t fold(crc5_t c, byte_t d);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb = c[4] ^ d[i];
            c = {c[3:0], 1'b0};
            if (fb) begin
                c = c ^ `COM_CRC5_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q <= `COM_CRC5_INIT;
        end else if (clr) begin
            crc_q <= `COM_CRC5_INIT;
        end else if (en) begin
            crc_q <= fold(crc_q, din);
        end
    end

    assign crc = ~crc_q;

endmodule

// ==== hdl/com_pkg.sv ====
package com_pkg;

    // ========================================================================
    // vector types.
    // ========================================================================
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  addr_t;
    typedef logic [4:0]  crc5_t;
    typedef logic [15:0] crc16_t;

    // packet type reported with fs.
    typedef enum logic [3:0] {
        NONE  = 4'd0,
        ACK   = 4'd1,
        NAK   = 4'd2,
        STALL = 4'd3,
        CMD   = 4'd8,
        DATA0 = 4'd13,
        DATA1 = 4'd14,
        ERROR = 4'd15
    } pkt_type_e;

    // parser states.
    typedef enum logic [3:0] {
        IDLE,
        WAIT,
        RPID,
        DLEN,
        WORK,
        CRC5,
        CRC16,
        DONE,
        EROR
    } rx_state_e;

endpackage

// ==== hdl/com_cfg.svh ====
`ifndef COM_CFG_SVH
`define COM_CFG_SVH

// ===========================================================================
// packet identifiers.
// ===========================================================================
`define COM_PID_SYNC    8'h01
`define COM_PID_CMD     8'h1E
`define COM_PID_DATA0   8'hC3
`define COM_PID_DATA1   8'h4B
`define COM_PID_ACK     8'h2D
`define COM_PID_NAK     8'hA5
`define COM_PID_STL     8'hE1

// header nibble of the first payload byte.
`define COM_HEAD_DIDX   4'h9
`define COM_HEAD_DDIDX  4'h1
`define COM_HEAD_DPARAM 4'h5

// region base addresses in the parameter RAM.
`define COM_BASE_DIDX   8'h10
`define COM_BASE_DDIDX  8'h20
`define COM_BASE_DPARAM 8'h80

`define COM_MAX_LEN     16'd64

// crc-5 is x^5+x^2+1, crc-16 is 8005 in reflected form.
`define COM_CRC5_POLY   5'h05
`define COM_CRC5_INIT   5'h1F
`define COM_CRC16_POLY  16'hA001
`define COM_CRC16_INIT  16'hFFFF

`endif
